// File: src/hist_pkg.sv
`default_nettype none

package hist_pkg;

    // default geometry, overridden from the top level
    // bin code width, bins per histogram is 2**BIN_BITS
    localparam int BIN_BITS_DEF = 3;
    // saturating count width
    localparam int COUNT_BITS_DEF = 2;
    // pixels held in one bank
    localparam int PIXELS_DEF = 4;
    // hits taken per pixel before moving on
    localparam int HITS_PER_PIXEL_DEF = 3;
    // full pixel sweeps per frame
    localparam int ACQS_DEF = 2;

    // derived from the defaults above
    localparam int BINS_DEF = 1 << BIN_BITS_DEF;
    localparam int PIX_BITS_DEF = (PIXELS_DEF > 1) ? $clog2(PIXELS_DEF) : 1;
    // entries in one bank, pixel-major
    localparam int ENTRIES_DEF = PIXELS_DEF * BINS_DEF;
    // hits that make up one frame
    localparam int HITS_PER_FRAME_DEF = PIXELS_DEF * HITS_PER_PIXEL_DEF * ACQS_DEF;
    // largest count before saturation
    localparam int COUNT_MAX_DEF = (1 << COUNT_BITS_DEF) - 1;

endpackage

`default_nettype wire

// File: src/hist_sequencer.sv
`default_nettype none

module hist_sequencer
    import hist_pkg::*;
#(
    parameter int PIXELS = PIXELS_DEF,
    parameter int HITS_PER_PIXEL = HITS_PER_PIXEL_DEF,
    parameter int ACQS = ACQS_DEF,
    localparam int PIX_BITS = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  wire logic                clk,
    input  wire logic                combin_res,
    input  wire logic                hit,
    output logic      [PIX_BITS-1:0] pixel,
    output logic                     frame_done,
    output logic                     bank_sel
);

    // counter widths, at least one bit each
    localparam int HIT_BITS = (HITS_PER_PIXEL > 1) ? $clog2(HITS_PER_PIXEL) : 1;
    localparam int ACQ_BITS = (ACQS > 1) ? $clog2(ACQS) : 1;

    // hits seen on the current pixel
    logic [HIT_BITS-1:0] hit_cnt;
    // sweeps done in the current frame
    logic [ACQ_BITS-1:0] acq_cnt;

    // wrap conditions of each level
    logic hit_last;
    logic pix_last;
    logic acq_last;
    logic frame_last;

    assign hit_last = (hit_cnt == HIT_BITS'(HITS_PER_PIXEL - 1));
    assign pix_last = (pixel == PIX_BITS'(PIXELS - 1));
    assign acq_last = (acq_cnt == ACQ_BITS'(ACQS - 1));
    // this hit closes the frame
    assign frame_last = hit_last && pix_last && acq_last;

    // hit counter, steps on every hit
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            hit_cnt <= '0;
        end else if (hit) begin
            if (hit_last) begin
                hit_cnt <= '0;
            end else begin
                hit_cnt <= hit_cnt + 1'b1;
            end
        end
    end

    // pixel index, steps when the hit counter wraps
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            pixel <= '0;
        end else if (hit && hit_last) begin
            if (pix_last) begin
                pixel <= '0;
            end else begin
                pixel <= pixel + 1'b1;
            end
        end
    end

    // acquisition counter, steps once per pixel sweep
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            acq_cnt <= '0;
        end else if (hit && hit_last && pix_last) begin
            if (acq_last) begin
                acq_cnt <= '0;
            end else begin
                acq_cnt <= acq_cnt + 1'b1;
            end
        end
    end

    // frame end pulse and bank swap on the same edge
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            frame_done <= 1'b0;
            bank_sel   <= 1'b0;
        end else begin
            frame_done <= hit && frame_last;
            if (hit && frame_last) begin
                bank_sel <= ~bank_sel;
            end
        end
    end

    // a frame is always longer than one hit, so no back-to-back pulses
    a_frame_done_single: assert property (
        @(posedge clk) disable iff (!combin_res)
        frame_done |=> !frame_done
    ) else $error("frame_done held for two cycles");

endmodule

`default_nettype wire

// File: src/hist_bank.sv
`default_nettype none

module hist_bank
    import hist_pkg::*;
#(
    parameter int BIN_BITS = BIN_BITS_DEF,
    parameter int COUNT_BITS = COUNT_BITS_DEF,
    parameter int PIXELS = PIXELS_DEF,
    localparam int PIX_BITS = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  wire logic                  clk,
    input  wire logic                  combin_res,
    input  wire logic                  clear,
    input  wire logic                  wr_en,
    input  wire logic [PIX_BITS-1:0]   wr_pixel,
    input  wire logic [BIN_BITS-1:0]   wr_bin,
    output logic      [COUNT_BITS-1:0] count,
    output logic                       count_valid,
    input  wire logic                  rd_en,
    input  wire logic [PIX_BITS-1:0]   rd_pixel,
    input  wire logic [BIN_BITS-1:0]   rd_bin,
    output logic      [COUNT_BITS-1:0] rd_data
);

    // one entry per pixel and bin, pixel-major
    localparam int ENTRIES = PIXELS << BIN_BITS;
    localparam int ADDR_BITS = PIX_BITS + BIN_BITS;
    localparam logic [COUNT_BITS-1:0] COUNT_MAX = '1;

    // histogram counts
    logic [COUNT_BITS-1:0] mem [ENTRIES];
    // set on first write, dropped by clear
    logic [ENTRIES-1:0] valid;

    logic [ADDR_BITS-1:0]  wr_addr;
    logic [ADDR_BITS-1:0]  rd_addr;
    // entry already holds a count of this frame
    logic                  wr_hit_valid;
    logic [COUNT_BITS-1:0] wr_next;

    // bins per pixel is a power of two, so concatenation is pixel*bins+bin
    assign wr_addr = {wr_pixel, wr_bin};
    assign rd_addr = {rd_pixel, rd_bin};

    // a write alongside clear starts over from one
    assign wr_hit_valid = valid[wr_addr] && !clear;

    // increment, held at the top instead of wrapping
    always_comb begin
        if (!wr_hit_valid) begin
            wr_next = COUNT_BITS'(1);
        end else if (mem[wr_addr] == COUNT_MAX) begin
            wr_next = COUNT_MAX;
        end else begin
            wr_next = mem[wr_addr] + 1'b1;
        end
    end

    // count storage and live count
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_next;
            count        <= wr_next;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            count_valid <= 1'b0;
        end else begin
            count_valid <= wr_en;
        end
    end

    // valid bits, clear first so a same-cycle write survives
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            valid <= '0;
        end else begin
            if (clear) begin
                valid <= '0;
            end
            if (wr_en) begin
                valid[wr_addr] <= 1'b1;
            end
        end
    end

    // read port, one cycle latency
    // idle or unwritten gives zero, so the top can merge both banks
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rd_data <= '0;
        end else if (rd_en && valid[rd_addr]) begin
            rd_data <= mem[rd_addr];
        end else begin
            rd_data <= '0;
        end
    end

    // the sequencer must keep its pixel index inside this bank
    a_wr_pixel_range: assert property (
        @(posedge clk) disable iff (!combin_res)
        wr_en |-> (int'(wr_pixel) < PIXELS)
    ) else $error("write pixel %0d out of range", wr_pixel);

endmodule

`default_nettype wire

// File: src/hist_readout.sv
`default_nettype none

module hist_readout
    import hist_pkg::*;
#(
    parameter int BIN_BITS = BIN_BITS_DEF,
    parameter int COUNT_BITS = COUNT_BITS_DEF,
    parameter int PIXELS = PIXELS_DEF,
    localparam int PIX_BITS = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  wire logic                  clk,
    input  wire logic                  combin_res,
    input  wire logic                  frame_done,
    output logic                       rd_en,
    output logic      [PIX_BITS-1:0]   rd_pixel,
    output logic      [BIN_BITS-1:0]   rd_bin,
    input  wire logic [COUNT_BITS-1:0] rd_data,
    output logic                       rd_valid,
    output logic      [PIX_BITS-1:0]   rd_pixel_out,
    output logic      [BIN_BITS-1:0]   rd_bin_out,
    output logic      [COUNT_BITS-1:0] rd_count,
    output logic                       overrun
);

    // scan in progress
    logic busy;
    logic bin_last;
    logic pix_last;

    assign bin_last = (rd_bin == '1);
    assign pix_last = (rd_pixel == PIX_BITS'(PIXELS - 1));

    // no read while the banks swap, the scan restarts next cycle
    assign rd_en = busy && !frame_done;

    // address scan, bin-minor
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            busy     <= 1'b0;
            rd_pixel <= '0;
            rd_bin   <= '0;
            overrun  <= 1'b0;
        end else begin
            // new frame while still busy means the old scan is lost
            overrun <= frame_done && busy;
            if (frame_done) begin
                busy     <= 1'b1;
                rd_pixel <= '0;
                rd_bin   <= '0;
            end else if (busy) begin
                rd_bin <= rd_bin + 1'b1;
                if (bin_last) begin
                    if (pix_last) begin
                        busy     <= 1'b0;
                        rd_pixel <= '0;
                    end else begin
                        rd_pixel <= rd_pixel + 1'b1;
                    end
                end
            end
        end
    end

    // address delayed one stage to meet the bank read latency
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            rd_valid     <= 1'b0;
            rd_pixel_out <= '0;
            rd_bin_out   <= '0;
        end else begin
            rd_valid     <= rd_en;
            rd_pixel_out <= rd_pixel;
            rd_bin_out   <= rd_bin;
        end
    end

    // bank data already lines up with rd_valid
    assign rd_count = rd_data;

    // reported entry must name a pixel that exists
    a_rd_pixel_range: assert property (
        @(posedge clk) disable iff (!combin_res)
        rd_valid |-> (int'(rd_pixel_out) < PIXELS)
    ) else $error("readout pixel %0d out of range", rd_pixel_out);

endmodule

`default_nettype wire

// File: src/hist_top.sv
`default_nettype none

module hist_top
    import hist_pkg::*;
#(
    parameter int BIN_BITS = BIN_BITS_DEF,
    parameter int COUNT_BITS = COUNT_BITS_DEF,
    parameter int PIXELS = PIXELS_DEF,
    parameter int HITS_PER_PIXEL = HITS_PER_PIXEL_DEF,
    parameter int ACQS = ACQS_DEF,
    localparam int PIX_BITS = (PIXELS > 1) ? $clog2(PIXELS) : 1
) (
    input  wire logic                  clk,
    input  wire logic                  combin_res,
    input  wire logic                  hit,
    input  wire logic [BIN_BITS-1:0]   bin,
    output logic      [COUNT_BITS-1:0] count,
    output logic                       count_valid,
    output logic                       frame_done,
    output logic                       bank_sel,
    output logic                       rd_valid,
    output logic      [PIX_BITS-1:0]   rd_pixel,
    output logic      [BIN_BITS-1:0]   rd_bin,
    output logic      [COUNT_BITS-1:0] rd_count,
    output logic                       overrun
);

    // current pixel from the sequencer
    logic [PIX_BITS-1:0] seq_pixel;

    // readout address into the finished bank
    logic                rd_en;
    logic [PIX_BITS-1:0] rd_addr_pixel;
    logic [BIN_BITS-1:0] rd_addr_bin;
    logic [COUNT_BITS-1:0] rd_data;

    // per-bank steering, bank 0 writes while bank_sel is low
    logic [1:0] wr_en_b;
    logic [1:0] clear_b;
    logic [1:0] rd_en_b;
    logic [1:0] cv_b;
    logic [COUNT_BITS-1:0] cnt_b [2];
    logic [COUNT_BITS-1:0] rdd_b [2];

    assign wr_en_b = {hit && bank_sel, hit && !bank_sel};
    // frame_done clears the bank that has just become the writer
    assign clear_b = {frame_done && bank_sel, frame_done && !bank_sel};
    assign rd_en_b = {rd_en && !bank_sel, rd_en && bank_sel};

    hist_sequencer #(
        .PIXELS(PIXELS), .HITS_PER_PIXEL(HITS_PER_PIXEL), .ACQS(ACQS)
    ) seq_i (
        .clk(clk), .combin_res(combin_res), .hit(hit), .pixel(seq_pixel),
        .frame_done(frame_done), .bank_sel(bank_sel)
    );

    hist_bank #(.BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS), .PIXELS(PIXELS)) bank0_i (
        .clk(clk), .combin_res(combin_res), .clear(clear_b[0]), .wr_en(wr_en_b[0]),
        .wr_pixel(seq_pixel), .wr_bin(bin), .count(cnt_b[0]), .count_valid(cv_b[0]),
        .rd_en(rd_en_b[0]), .rd_pixel(rd_addr_pixel), .rd_bin(rd_addr_bin), .rd_data(rdd_b[0])
    );

    hist_bank #(.BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS), .PIXELS(PIXELS)) bank1_i (
        .clk(clk), .combin_res(combin_res), .clear(clear_b[1]), .wr_en(wr_en_b[1]),
        .wr_pixel(seq_pixel), .wr_bin(bin), .count(cnt_b[1]), .count_valid(cv_b[1]),
        .rd_en(rd_en_b[1]), .rd_pixel(rd_addr_pixel), .rd_bin(rd_addr_bin), .rd_data(rdd_b[1])
    );

    // live count follows whichever bank took the hit
    // its own valid, since bank_sel may flip in between
    assign count_valid = |cv_b;
    assign count = cv_b[1] ? cnt_b[1] : cnt_b[0];

    // idle bank reads zero
    assign rd_data = rdd_b[0] | rdd_b[1];

    hist_readout #(.BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS), .PIXELS(PIXELS)) readout_i (
        .clk(clk), .combin_res(combin_res), .frame_done(frame_done), .rd_en(rd_en),
        .rd_pixel(rd_addr_pixel), .rd_bin(rd_addr_bin), .rd_data(rd_data),
        .rd_valid(rd_valid), .rd_pixel_out(rd_pixel), .rd_bin_out(rd_bin),
        .rd_count(rd_count), .overrun(overrun)
    );

endmodule

`default_nettype wire

// File: include/tb_hist_tasks.svh
`ifndef TB_HIST_TASKS_SVH
`define TB_HIST_TASKS_SVH

task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "stopped at the first error");
endtask

task automatic check_count(input string name, input logic [COUNT_BITS-1:0] expected,
        input logic [COUNT_BITS-1:0] actual);
    if (actual !== expected) begin
        $display("Fail %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        abort_run();
    end
endtask

task automatic check_index(input string name, input logic [PIX_BITS-1:0] exp_pix,
        input logic [BIN_BITS-1:0] exp_bin, input logic [PIX_BITS-1:0] act_pix,
        input logic [BIN_BITS-1:0] act_bin);
    if (act_pix !== exp_pix || act_bin !== exp_bin) begin
        $display("Fail %0t: %s expected %0d/%0d actual %0d/%0d", $time, name,
            exp_pix, exp_bin, act_pix, act_bin);
        abort_run();
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        $display("Fail %0t: %s expected %b actual %b", $time, name, expected, actual);
        abort_run();
    end
endtask

// compare every output against the model once per cycle
task automatic check_outputs();
    int d;
    int n;
    int e;
    logic exp_fd;
    logic exp_ov;
    n = -1;
    exp_fd = 1'b0;
    exp_ov = 1'b0;
    check_flag("count_valid", exp_cv, count_valid);
    if (exp_cv) begin
        check_count("count", exp_cnt, count);
        if (count == COUNT_TOP) sat_seen++;
    end
    if (frames > 0) begin
        d = cyc - fd_cyc[frames-1];
        exp_fd = (d == 0);
        if (d >= 2 && d <= ENTRIES + 1) begin
            n = frames - 1;
        end else if (d == 0 && frames > 1) begin
            // tail of the cut scan still shows on the frame_done cycle
            d = cyc - fd_cyc[frames-2];
            if (d >= 2 && d <= ENTRIES + 1) n = frames - 2;
        end
    end
    // new frame while the old scan still runs
    if (frames > 1) begin
        exp_ov = (cyc == fd_cyc[frames-1] + 1) &&
            (fd_cyc[frames-1] - fd_cyc[frames-2] <= ENTRIES);
    end
    check_flag("frame_done", exp_fd, frame_done);
    check_flag("bank_sel", m_bank_sel, bank_sel);
    check_flag("overrun", exp_ov, overrun);
    if (overrun) overruns++;
    check_flag("rd_valid", n >= 0, rd_valid);
    if (n >= 0) begin
        // entries run pixel-major and bin-minor
        e = cyc - fd_cyc[n] - 2;
        check_index("rd_pixel/rd_bin", PIX_BITS'(e / BINS), BIN_BITS'(e % BINS),
            rd_pixel, rd_bin);
        check_count("rd_count", snap[fd_bank[n]][e], rd_count);
        seen[n]++;
    end
endtask

// freeze the finished bank, swap, clear the new writer
task automatic end_frame(input int w);
    for (int e = 0; e < ENTRIES; e++) begin
        snap[w][e] = m_valid[w][e] ? m_mem[w][e] : '0;
        m_valid[1 - w][e] = 1'b0;
    end
    fd_cyc[frames] = cyc + 1;
    fd_bank[frames] = w;
    frames++;
    m_bank_sel = ~m_bank_sel;
endtask

task automatic model_hit(input logic [BIN_BITS-1:0] b);
    int w;
    int a;
    w = int'(m_bank_sel);
    a = m_pixel * BINS + int'(b);
    // first write gives one and later writes stop at the top
    if (!m_valid[w][a]) begin
        m_mem[w][a] = COUNT_BITS'(1);
    end else if (m_mem[w][a] != COUNT_TOP) begin
        m_mem[w][a] = m_mem[w][a] + 1'b1;
    end
    m_valid[w][a] = 1'b1;
    exp_cv = 1'b1;
    exp_cnt = m_mem[w][a];
    m_hits++;
    if (m_hits == HITS_PER_PIXEL) begin
        m_hits = 0;
        m_pixel++;
        if (m_pixel == PIXELS) begin
            m_pixel = 0;
            m_acq++;
            if (m_acq == ACQS) begin
                m_acq = 0;
                end_frame(w);
            end
        end
    end
endtask

// check at the falling edge, then drive the next inputs
task automatic run_cycle(input logic h, input logic [BIN_BITS-1:0] b);
    @(negedge clk);
    cyc++;
    check_outputs();
    hit = h;
    bin = b;
    if (h) model_hit(b);
    else exp_cv = 1'b0;
endtask

task automatic drive_frame(input int gap_min, input int gap_max, input bit hold);
    int gap;
    logic [BIN_BITS-1:0] b;
    for (int i = 0; i < FRAME_HITS; i++) begin
        gap = gap_min + int'($unsigned($random(seed)) % (gap_max - gap_min + 1));
        b = BIN_BITS'($unsigned($random(seed)) % BINS);
        if (hold && m_pixel == 0) b = HOLD_BIN;
        repeat (gap) run_cycle(1'b0, '0);
        run_cycle(1'b1, b);
    end
endtask

// last entry lands ENTRIES+1 cycles after frame_done
task automatic wait_scan_end(input int n);
    while (cyc < fd_cyc[n] + ENTRIES + 1) run_cycle(1'b0, '0);
    if (seen[n] != ENTRIES) begin
        $display("Readout of frame %0d gave %0d of %0d entries", n, seen[n], ENTRIES);
        abort_run();
    end
endtask

task automatic test_after_reset();
    check_flag("count_valid", 1'b0, count_valid);
    check_flag("frame_done", 1'b0, frame_done);
    check_flag("rd_valid", 1'b0, rd_valid);
    check_flag("overrun", 1'b0, overrun);
    check_flag("bank_sel", 1'b0, bank_sel);
    run_cycle(1'b0, '0);
endtask

task automatic test_live_count();
    drive_frame(0, GAP_MAX, 1'b1);
    if (sat_seen < SAT_MIN) begin
        $display("Live count reached the maximum only %0d times", sat_seen);
        abort_run();
    end
endtask

task automatic test_frame_readout();
    int waited;
    waited = 0;
    while (!rd_valid && waited < ENTRIES) begin
        run_cycle(1'b0, '0);
        waited++;
    end
    if (!rd_valid || cyc != fd_cyc[0] + 2) begin
        $display("First readout entry missing two cycles after frame_done");
        abort_run();
    end
endtask

// one idle cycle per hit so this frame outlasts the first scan
task automatic test_bank_swap();
    drive_frame(1, 1, 1'b0);
    wait_scan_end(0);
    wait_scan_end(1);
    if (overruns != 0) begin
        $display("Overrun raised although every scan finished in time");
        abort_run();
    end
endtask

// second frame starts in the clear cycle and ends mid scan
task automatic test_overrun();
    drive_frame(0, 0, 1'b0);
    drive_frame(0, 0, 1'b0);
    wait_scan_end(3);
    if (overruns != 1 || seen[2] >= ENTRIES) begin
        $display("Expected one overrun cutting the third scan, saw %0d", overruns);
        abort_run();
    end
endtask

`endif

// File: verif/tb_hist_top.sv
`default_nettype none

module tb_hist_top
    import hist_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // DUT geometry taken from the package defaults
    localparam int BIN_BITS = BIN_BITS_DEF;
    localparam int COUNT_BITS = COUNT_BITS_DEF;
    localparam int PIXELS = PIXELS_DEF;
    localparam int HITS_PER_PIXEL = HITS_PER_PIXEL_DEF;
    localparam int ACQS = ACQS_DEF;
    localparam int PIX_BITS = (PIXELS > 1) ? $clog2(PIXELS) : 1;
    localparam int BINS = 1 << BIN_BITS;
    localparam int ENTRIES = PIXELS * BINS;
    localparam int FRAME_HITS = PIXELS * HITS_PER_PIXEL * ACQS;
    localparam logic [COUNT_BITS-1:0] COUNT_TOP = '1;

    // timing of the run
    localparam int CLK_NS = 40;
    localparam int RESET_CYCLES = 4;
    localparam int FRAMES = 4;
    localparam int GAP_MAX = 2;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + FRAMES * (FRAME_HITS * (GAP_MAX + 1) + ENTRIES + 4) + 100;

    // pixel 0 of the first frame hammers this bin
    localparam logic [BIN_BITS-1:0] HOLD_BIN = BIN_BITS'(5);
    // six hits on one bin give 1 2 3 3 3 3
    localparam int SAT_MIN = 4;

    int seed = 61453;

    logic                  clk;
    logic                  combin_res;
    logic                  hit;
    logic [BIN_BITS-1:0]   bin;
    logic [COUNT_BITS-1:0] count;
    logic                  count_valid;
    logic                  frame_done;
    logic                  bank_sel;
    logic                  rd_valid;
    logic [PIX_BITS-1:0]   rd_pixel;
    logic [BIN_BITS-1:0]   rd_bin;
    logic [COUNT_BITS-1:0] rd_count;
    logic                  overrun;

    // reference model of both banks and the sequencing
    int cyc;
    int frames;
    int overruns;
    int sat_seen;
    int fd_cyc[FRAMES];
    int fd_bank[FRAMES];
    int seen[FRAMES];
    int m_pixel;
    int m_hits;
    int m_acq;
    logic m_bank_sel;
    logic m_valid [2][ENTRIES];
    logic [COUNT_BITS-1:0] m_mem [2][ENTRIES];
    // finished bank as it stood at frame end
    logic [COUNT_BITS-1:0] snap [2][ENTRIES];
    // live count expected after the next edge
    logic exp_cv;
    logic [COUNT_BITS-1:0] exp_cnt;

    `include "tb_hist_tasks.svh"

    hist_top #(
        .BIN_BITS(BIN_BITS), .COUNT_BITS(COUNT_BITS), .PIXELS(PIXELS),
        .HITS_PER_PIXEL(HITS_PER_PIXEL), .ACQS(ACQS)
    ) dut_i (
        .clk(clk), .combin_res(combin_res), .hit(hit), .bin(bin), .count(count),
        .count_valid(count_valid), .frame_done(frame_done), .bank_sel(bank_sel),
        .rd_valid(rd_valid), .rd_pixel(rd_pixel), .rd_bin(rd_bin), .rd_count(rd_count),
        .overrun(overrun)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // hard limit on the whole run
    initial begin
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        combin_res = 1'b0;
        hit = 1'b0;
        bin = '0;
        cyc = 0;
        frames = 0;
        overruns = 0;
        sat_seen = 0;
        m_pixel = 0;
        m_hits = 0;
        m_acq = 0;
        m_bank_sel = 1'b0;
        exp_cv = 1'b0;
        exp_cnt = '0;
        for (int i = 0; i < FRAMES; i++) begin
            seen[i] = 0;
        end
        for (int e = 0; e < ENTRIES; e++) begin
            m_valid[0][e] = 1'b0;
            m_valid[1][e] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        combin_res = 1'b1;

        test_after_reset();
        test_live_count();
        test_frame_readout();
        test_bank_swap();
        test_overrun();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
src/hist_pkg.sv
src/hist_sequencer.sv
src/hist_bank.sv
src/hist_readout.sv
src/hist_top.sv
verif/tb_hist_top.sv

// File: Makefile
# tool and file locations, all overridable from the command line
VERILATOR ?= verilator
TOP       ?= tb_hist_top
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
